// ==== Bender.yml ====
package:
  name: ooo_backend

sources:
  - source/ooo_pkg.sv
  - source/cdb_if.sv
  - source/issue_if.sv
  - source/rob.sv
  - source/alu_unit.sv
  - source/mul_unit.sv
  - source/ooo_backend.sv
  - target: test
    files:
      - verif/tb_clock.sv
      - verif/tb_ooo_backend.sv

// ==== files.f ====
source/ooo_pkg.sv
source/cdb_if.sv
source/issue_if.sv
source/rob.sv
source/alu_unit.sv
source/mul_unit.sv
source/ooo_backend.sv
verif/tb_clock.sv
verif/tb_ooo_backend.sv

// ==== source/alu_unit.sv ====
module alu_unit (
    input  logic clk,
    input  logic rst_n_i,
    issue_if.unit issue,
    cdb_if.unit   cdb
);
    import ooo_pkg::*;

    logic                 start;
    logic [XLEN-1:0]      res_d;
    logic                 taken_d;
    logic                 valid_q;
    logic [ROB_IDX_W-1:0] idx_q;
    logic [XLEN-1:0]      res_q;
    logic                 taken_q;
    logic [XLEN-1:0]      target_q;

    // everything except multiplies lands here
    assign start = issue.valid && (issue.op != OP_MUL);

    always_comb begin
        res_d   = '0;
        taken_d = 1'b0;
        case (issue.op)
            OP_ADD: res_d = issue.rs1_val + issue.rs2_val;
            OP_SUB: res_d = issue.rs1_val - issue.rs2_val;
            OP_AND: res_d = issue.rs1_val & issue.rs2_val;
            OP_XOR: res_d = issue.rs1_val ^ issue.rs2_val;
            // branches report zero data, only the outcome matters
            OP_BEQ: taken_d = (issue.rs1_val == issue.rs2_val);
            OP_BNE: taken_d = (issue.rs1_val != issue.rs2_val);
            default: res_d = '0;
        endcase
    end

    // strobe register, killed by a flush
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= start && !issue.flush;
        end
    end

    // result payload
    always_ff @(posedge clk) begin
        if (start) begin
            idx_q    <= issue.rob_idx;
            res_q    <= res_d;
            taken_q  <= taken_d;
            target_q <= issue.pc + issue.imm;
        end
    end

    assign cdb.valid     = valid_q;
    assign cdb.rob_idx   = idx_q;
    assign cdb.data      = res_q;
    assign cdb.br_taken  = taken_q;
    assign cdb.br_target = target_q;

    // nothing from before a redirect may reach the rob
    a_no_strobe_after_flush: assert property (@(posedge clk) disable iff (!rst_n_i)
        issue.flush |=> !cdb.valid);

endmodule

// ==== source/cdb_if.sv ====
interface cdb_if;
    import ooo_pkg::*;

    // one strobe per finished result
    logic                 valid;
    // rob slot the result belongs to
    logic [ROB_IDX_W-1:0] rob_idx;
    logic [XLEN-1:0]      data;
    // branch outcome, low from the multiplier
    logic                 br_taken;
    logic [XLEN-1:0]      br_target;

    // functional unit side
    modport unit (
        output valid, rob_idx, data, br_taken, br_target
    );

    // reorder buffer side
    modport rob (
        input valid, rob_idx, data, br_taken, br_target
    );

endinterface

// ==== source/issue_if.sv ====
interface issue_if;
    import ooo_pkg::*;

    // pulses once per accepted dispatch
    logic                 valid;
    op_t                  op;
    // tail slot given to the instruction
    logic [ROB_IDX_W-1:0] rob_idx;
    logic [XLEN-1:0]      rs1_val;
    logic [XLEN-1:0]      rs2_val;
    logic [XLEN-1:0]      pc;
    logic [XLEN-1:0]      imm;
    // taken branch retiring, drop everything in flight
    logic                 flush;

    modport rob (
        output valid, op, rob_idx, rs1_val, rs2_val, pc, imm, flush
    );

    modport unit (
        input valid, op, rob_idx, rs1_val, rs2_val, pc, imm, flush
    );

endinterface

// ==== source/mul_unit.sv ====
module mul_unit (
    input  logic clk,
    input  logic rst_n_i,
    issue_if.unit issue,
    cdb_if.unit   cdb
);
    import ooo_pkg::*;

    logic                 start;
    // stage 1, 16x16 partial products
    logic                 s1_valid;
    logic [ROB_IDX_W-1:0] s1_idx;
    logic [31:0]          s1_pp_ll;
    logic [15:0]          s1_pp_lh;
    logic [15:0]          s1_pp_hl;
    // stage 2, cross terms summed
    logic                 s2_valid;
    logic [ROB_IDX_W-1:0] s2_idx;
    logic [31:0]          s2_pp_ll;
    logic [15:0]          s2_cross;
    // stage 3, low word of the product
    logic                 s3_valid;
    logic [ROB_IDX_W-1:0] s3_idx;
    logic [XLEN-1:0]      s3_prod;

    assign start = issue.valid && (issue.op == OP_MUL);

    // valid chain, flush empties the whole pipe
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
            s3_valid <= 1'b0;
        end else if (issue.flush) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
            s3_valid <= 1'b0;
        end else begin
            s1_valid <= start;
            s2_valid <= s1_valid;
            s3_valid <= s2_valid;
        end
    end

    // hi x hi term falls above bit 31 and is dropped
    always_ff @(posedge clk) begin
        s1_idx   <= issue.rob_idx;
        s1_pp_ll <= issue.rs1_val[15:0] * issue.rs2_val[15:0];
        // only the low halves of the cross terms survive the shift
        s1_pp_lh <= issue.rs1_val[15:0] * issue.rs2_val[31:16];
        s1_pp_hl <= issue.rs1_val[31:16] * issue.rs2_val[15:0];

        s2_idx   <= s1_idx;
        s2_pp_ll <= s1_pp_ll;
        s2_cross <= s1_pp_lh + s1_pp_hl;

        s3_idx   <= s2_idx;
        s3_prod  <= s2_pp_ll + {s2_cross, 16'd0};
    end

    assign cdb.valid     = s3_valid;
    assign cdb.rob_idx   = s3_idx;
    assign cdb.data      = s3_prod;
    // multiplies never branch
    assign cdb.br_taken  = 1'b0;
    assign cdb.br_target = '0;

    // every result traces back to a mul issue three cycles earlier
    a_mul_latency: assert property (@(posedge clk) disable iff (!rst_n_i)
        cdb.valid |-> $past(start, 3) && ($past(issue.rob_idx, 3) == cdb.rob_idx));

endmodule

// ==== source/ooo_backend.sv ====
module ooo_backend (
    input  logic                        clk,
    input  logic                        rst_n_i,
    input  logic                        dispatch_valid_i,
    input  ooo_pkg::op_t                dispatch_op_i,
    input  logic [4:0]                  dispatch_rd_i,
    input  logic [ooo_pkg::XLEN-1:0]    dispatch_rs1_i,
    input  logic [ooo_pkg::XLEN-1:0]    dispatch_rs2_i,
    input  logic [ooo_pkg::XLEN-1:0]    dispatch_pc_i,
    input  logic [ooo_pkg::XLEN-1:0]    dispatch_imm_i,
    input  logic                        commit_ready_i,
    output logic                        full_o,
    output logic                        commit_valid_o,
    output logic [4:0]                  commit_rd_o,
    output logic [ooo_pkg::XLEN-1:0]    commit_data_o,
    output logic [ooo_pkg::XLEN-1:0]    commit_pc_o,
    output logic                        redirect_valid_o,
    output logic [ooo_pkg::XLEN-1:0]    redirect_pc_o
);

    // rob to units
    issue_if issue_bus ();
    // one result bus per unit
    cdb_if   alu_cdb ();
    cdb_if   mul_cdb ();

    rob u_rob (
        .clk              (clk),
        .rst_n_i          (rst_n_i),
        .dispatch_valid_i (dispatch_valid_i),
        .dispatch_op_i    (dispatch_op_i),
        .dispatch_rd_i    (dispatch_rd_i),
        .dispatch_rs1_i   (dispatch_rs1_i),
        .dispatch_rs2_i   (dispatch_rs2_i),
        .dispatch_pc_i    (dispatch_pc_i),
        .dispatch_imm_i   (dispatch_imm_i),
        .commit_ready_i   (commit_ready_i),
        .issue            (issue_bus.rob),
        .alu_cdb          (alu_cdb.rob),
        .mul_cdb          (mul_cdb.rob),
        .full_o           (full_o),
        .commit_valid_o   (commit_valid_o),
        .commit_rd_o      (commit_rd_o),
        .commit_data_o    (commit_data_o),
        .commit_pc_o      (commit_pc_o),
        .redirect_valid_o (redirect_valid_o),
        .redirect_pc_o    (redirect_pc_o)
    );

    // single cycle alu and branch unit
    alu_unit u_alu (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .issue   (issue_bus.unit),
        .cdb     (alu_cdb.unit)
    );

    // three stage multiplier
    mul_unit u_mul (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .issue   (issue_bus.unit),
        .cdb     (mul_cdb.unit)
    );

endmodule

// ==== source/ooo_pkg.sv ====
package ooo_pkg;

    // reorder buffer size
    localparam int ROB_DEPTH = 16;
    localparam int ROB_IDX_W = 4;

    // datapath width
    localparam int XLEN = 32;

    // operations handled by the back end
    // only OP_MUL goes to the multiplier
    typedef enum logic [2:0] {
        OP_ADD = 3'd0,
        OP_SUB = 3'd1,
        OP_AND = 3'd2,
        OP_XOR = 3'd3,
        OP_MUL = 3'd4,
        OP_BEQ = 3'd5,
        OP_BNE = 3'd6
    } op_t;

    // life of one rob slot
    typedef enum logic [1:0] {
        RS_EMPTY = 2'd0,
        RS_WAIT  = 2'd1,
        RS_DONE  = 2'd2
    } rob_status_t;

    // one rob slot, 107 bits
    typedef struct packed {
        rob_status_t       status;
        op_t               op;
        // destination, zero for branches
        logic [4:0]        rd;
        logic [XLEN-1:0]   pc;
        // result from the cdb
        logic [XLEN-1:0]   data;
        logic              br_taken;
        logic [XLEN-1:0]   br_target;
    } rob_entry_t;

    // branch ops resolve in the alu
    function automatic logic is_branch(op_t op);
        return (op == OP_BEQ) || (op == OP_BNE);
    endfunction

endpackage

// ==== source/rob.sv ====
module rob (
    input  logic                        clk,
    input  logic                        rst_n_i,
    input  logic                        dispatch_valid_i,
    input  ooo_pkg::op_t                dispatch_op_i,
    input  logic [4:0]                  dispatch_rd_i,
    input  logic [ooo_pkg::XLEN-1:0]    dispatch_rs1_i,
    input  logic [ooo_pkg::XLEN-1:0]    dispatch_rs2_i,
    input  logic [ooo_pkg::XLEN-1:0]    dispatch_pc_i,
    input  logic [ooo_pkg::XLEN-1:0]    dispatch_imm_i,
    input  logic                        commit_ready_i,
    issue_if.rob                        issue,
    cdb_if.rob                          alu_cdb,
    cdb_if.rob                          mul_cdb,
    output logic                        full_o,
    output logic                        commit_valid_o,
    output logic [4:0]                  commit_rd_o,
    output logic [ooo_pkg::XLEN-1:0]    commit_data_o,
    output logic [ooo_pkg::XLEN-1:0]    commit_pc_o,
    output logic                        redirect_valid_o,
    output logic [ooo_pkg::XLEN-1:0]    redirect_pc_o
);
    import ooo_pkg::*;

    localparam logic [ROB_IDX_W:0] DEPTH_CNT = (ROB_IDX_W + 1)'(ROB_DEPTH);

    rob_entry_t           rob_q [ROB_DEPTH];
    rob_entry_t           new_entry;
    logic [ROB_IDX_W-1:0] head_q;
    logic [ROB_IDX_W-1:0] tail_q;
    // one extra bit so a full table is representable
    logic [ROB_IDX_W:0]   count_q;
    logic                 accept;
    logic                 retire;
    logic                 flush;

    assign full_o = (count_q == DEPTH_CNT);

    // flush wins over a dispatch in the same cycle
    assign accept = dispatch_valid_i && !full_o && !redirect_valid_o;

    // in-order retirement from the head
    assign retire = (rob_q[head_q].status == RS_DONE) && commit_ready_i;
    assign flush  = retire && rob_q[head_q].br_taken;

    assign commit_valid_o   = retire;
    assign commit_rd_o      = rob_q[head_q].rd;
    assign commit_data_o    = rob_q[head_q].data;
    assign commit_pc_o      = rob_q[head_q].pc;
    assign redirect_valid_o = flush;
    assign redirect_pc_o    = rob_q[head_q].br_target;

    // issue straight from the dispatch port, tagged with the tail slot
    assign issue.valid   = accept;
    assign issue.op      = dispatch_op_i;
    assign issue.rob_idx = tail_q;
    assign issue.rs1_val = dispatch_rs1_i;
    assign issue.rs2_val = dispatch_rs2_i;
    assign issue.pc      = dispatch_pc_i;
    assign issue.imm     = dispatch_imm_i;
    assign issue.flush   = flush;

    // fresh slot for the tail
    always_comb begin
        new_entry        = '0;
        new_entry.status = RS_WAIT;
        new_entry.op     = dispatch_op_i;
        // branches never write a register
        new_entry.rd     = is_branch(dispatch_op_i) ? 5'd0 : dispatch_rd_i;
        new_entry.pc     = dispatch_pc_i;
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
            for (int i = 0; i < ROB_DEPTH; i++) begin
                rob_q[i].status <= RS_EMPTY;
            end
        end else if (flush) begin
            // taken branch retires, every younger slot goes away
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
            for (int i = 0; i < ROB_DEPTH; i++) begin
                rob_q[i].status <= RS_EMPTY;
            end
        end else begin
            // allocate, index wraps at the power-of-two depth
            if (accept) begin
                rob_q[tail_q] <= new_entry;
                tail_q        <= tail_q + 1'b1;
            end

            // writeback from both buses, indices always differ
            if (alu_cdb.valid) begin
                rob_q[alu_cdb.rob_idx].status    <= RS_DONE;
                rob_q[alu_cdb.rob_idx].data      <= alu_cdb.data;
                rob_q[alu_cdb.rob_idx].br_taken  <= alu_cdb.br_taken;
                rob_q[alu_cdb.rob_idx].br_target <= alu_cdb.br_target;
            end
            if (mul_cdb.valid) begin
                rob_q[mul_cdb.rob_idx].status    <= RS_DONE;
                rob_q[mul_cdb.rob_idx].data      <= mul_cdb.data;
                rob_q[mul_cdb.rob_idx].br_taken  <= mul_cdb.br_taken;
                rob_q[mul_cdb.rob_idx].br_target <= mul_cdb.br_target;
            end

            // commit frees the head
            if (retire) begin
                rob_q[head_q].status <= RS_EMPTY;
                head_q               <= head_q + 1'b1;
            end

            case ({accept, retire})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // no acceptance while full, so the tail slot is always free
    a_alloc_free: assert property (@(posedge clk) disable iff (!rst_n_i)
        issue.valid |-> (rob_q[tail_q].status == RS_EMPTY));

    // units only report on slots still waiting
    a_alu_cdb_live: assert property (@(posedge clk) disable iff (!rst_n_i)
        alu_cdb.valid |-> (rob_q[alu_cdb.rob_idx].status == RS_WAIT));
    a_mul_cdb_live: assert property (@(posedge clk) disable iff (!rst_n_i)
        mul_cdb.valid |-> (rob_q[mul_cdb.rob_idx].status == RS_WAIT));

    a_count_bound: assert property (@(posedge clk) disable iff (!rst_n_i)
        count_q <= DEPTH_CNT);

endmodule

// ==== verif/ooo_trace.txt ====
// one dispatch per line, hex words: op rd rs1 rs2 pc imm expected flags
// flags bit0 wrong path, bit1 taken branch, bit2 long commit stall
4 01 00001234 00005678 00000100 00000000 06260060 4
0 02 00000005 00000007 00000104 00000000 0000000c 0
1 03 00000010 00000003 00000108 00000000 0000000d 0
4 04 ffffffff 00000003 0000010c 00000000 fffffffd 0
2 05 f0f0f0f0 ff00ff00 00000110 00000000 f000f000 0
3 06 aaaaaaaa 55555555 00000114 00000000 ffffffff 0
4 07 00010001 00010001 00000118 00000000 00020001 0
5 00 00000001 00000002 0000011c 00000040 00000000 0
0 08 00000100 00000023 00000120 00000000 00000123 0
1 09 00000000 00000001 00000124 00000000 ffffffff 0
0 0a 11111111 22222222 00000128 00000000 33333333 0
4 0b 00000100 00000100 0000012c 00000000 00010000 0
1 0c 00000005 00000007 00000130 00000000 fffffffe 0
2 0d 0000ffff 12345678 00000134 00000000 00005678 0
3 0e 12345678 12345678 00000138 00000000 00000000 0
4 0f 00000011 00000011 0000013c 00000000 00000121 0
0 10 7fffffff 00000001 00000140 00000000 80000000 0
6 00 00000001 00000002 00000144 00000100 00000000 2
0 11 00000001 00000001 00000148 00000000 00000002 1
4 12 00000003 00000003 0000014c 00000000 00000009 1
3 13 0000000f 0000000f 00000150 00000000 00000000 1
0 14 00000020 00000022 00000244 00000000 00000042 0
4 15 00000007 00000006 00000248 00000000 0000002a 0
1 16 00000064 00000001 0000024c 00000000 00000063 0

// ==== verif/tb_clock.sv ====
module tb_clock (
    output logic clk,
    output logic rst_n_o
);
    timeunit 1ns;
    timeprecision 100ps;

    // 4 ns period, first rising edge at 2 ns
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // reset low for two cycles, released on a rising edge
    initial begin
        rst_n_o = 1'b0;
        repeat (2) @(posedge clk);
        rst_n_o <= 1'b1;
    end

endmodule

// ==== verif/tb_ooo_backend.sv ====
module tb_ooo_backend;
    timeunit 1ns;
    timeprecision 100ps;
    import ooo_pkg::*;

    // eight hex words per trace line
    localparam int LINES       = 24;
    localparam int COLS        = 8;
    localparam int CYCLE_LIMIT = 40 * LINES + 100;
    localparam int LONG_STALL  = 30;

    // flag column bits
    localparam int F_SHADOW = 0;
    localparam int F_TAKEN  = 1;
    localparam int F_STALL  = 2;

    logic              clk;
    logic              rst_n;
    logic              dispatch_valid_i;
    op_t               dispatch_op_i;
    logic [4:0]        dispatch_rd_i;
    logic [XLEN-1:0]   dispatch_rs1_i;
    logic [XLEN-1:0]   dispatch_rs2_i;
    logic [XLEN-1:0]   dispatch_pc_i;
    logic [XLEN-1:0]   dispatch_imm_i;
    logic              commit_ready_i;
    logic              full_o;
    logic              commit_valid_o;
    logic [4:0]        commit_rd_o;
    logic [XLEN-1:0]   commit_data_o;
    logic [XLEN-1:0]   commit_pc_o;
    logic              redirect_valid_o;
    logic [XLEN-1:0]   redirect_pc_o;

    logic [31:0]       trace_mem [LINES*COLS];
    // trace line numbers in program order with the oldest first
    int                exp_q [$];
    int                ptr;
    int                stall_left;
    int                cycles;
    int                errors;
    int                checks;
    int unsigned       seed;
    bit                pending_redirect;
    bit                timed_out;

    tb_clock u_clock (
        .clk     (clk),
        .rst_n_o (rst_n)
    );

    ooo_backend u_dut (
        .clk              (clk),
        .rst_n_i          (rst_n),
        .dispatch_valid_i (dispatch_valid_i),
        .dispatch_op_i    (dispatch_op_i),
        .dispatch_rd_i    (dispatch_rd_i),
        .dispatch_rs1_i   (dispatch_rs1_i),
        .dispatch_rs2_i   (dispatch_rs2_i),
        .dispatch_pc_i    (dispatch_pc_i),
        .dispatch_imm_i   (dispatch_imm_i),
        .commit_ready_i   (commit_ready_i),
        .full_o           (full_o),
        .commit_valid_o   (commit_valid_o),
        .commit_rd_o      (commit_rd_o),
        .commit_data_o    (commit_data_o),
        .commit_pc_o      (commit_pc_o),
        .redirect_valid_o (redirect_valid_o),
        .redirect_pc_o    (redirect_pc_o)
    );

    function automatic logic [31:0] word_at(int line, int col);
        return trace_mem[line * COLS + col];
    endfunction

    function automatic bit has_flag(int line, int pos);
        logic [31:0] flags;
        flags = word_at(line, 7);
        return flags[pos];
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("error: %s is %h, expected %h at %0t", name, actual, expected, $time);
        end
    endtask

    // on the falling edge drive the stall first and then the next trace line
    task automatic drive_inputs();
        int b;
        if (stall_left > 0) begin
            commit_ready_i = 1'b0;
            stall_left--;
        end else begin
            commit_ready_i = 1'b1;
            if ($urandom_range(5, 0) == 0) begin
                stall_left = $urandom_range(4, 1);
            end
        end
        // target path held back until the taken branch retires
        dispatch_valid_i = (ptr < LINES) && !(pending_redirect && !has_flag(ptr, F_SHADOW));
        if (dispatch_valid_i) begin
            b = ptr * COLS;
            dispatch_op_i  = op_t'(trace_mem[b][2:0]);
            dispatch_rd_i  = trace_mem[b + 1][4:0];
            dispatch_rs1_i = trace_mem[b + 2];
            dispatch_rs2_i = trace_mem[b + 3];
            dispatch_pc_i  = trace_mem[b + 4];
            dispatch_imm_i = trace_mem[b + 5];
        end
    endtask

    // sampled just before the rising edge once outputs settle
    task automatic sample_outputs();
        int line;
        bit take;
        take = dispatch_valid_i && !full_o && !redirect_valid_o;
        // model occupancy equals the rob count here
        check_value("full_o", full_o, exp_q.size() == ROB_DEPTH);
        // retirement stalls while commit_ready_i is low
        if (!commit_ready_i) begin
            check_value("commit_valid_o", commit_valid_o, 1'b0);
        end
        if (commit_valid_o) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("a commit appeared with no line outstanding at %0t", $time);
            end else begin
                line = exp_q.pop_front();
                if (has_flag(line, F_SHADOW)) begin
                    errors++;
                    $display("wrong-path trace line %0d committed at %0t", line, $time);
                end
                check_value("commit_pc_o", commit_pc_o, word_at(line, 4));
                check_value("commit_rd_o", commit_rd_o, word_at(line, 1));
                check_value("commit_data_o", commit_data_o, word_at(line, 6));
                check_value("redirect_valid_o", redirect_valid_o, has_flag(line, F_TAKEN));
                if (has_flag(line, F_TAKEN)) begin
                    check_value("redirect_pc_o", redirect_pc_o,
                                word_at(line, 4) + word_at(line, 5));
                end
            end
        end else begin
            check_value("redirect_valid_o", redirect_valid_o, 1'b0);
        end
        if (redirect_valid_o) begin
            // all younger lines squashed and the wrong path skipped
            exp_q.delete();
            pending_redirect = 1'b0;
            while (ptr < LINES && has_flag(ptr, F_SHADOW)) begin
                ptr++;
            end
        end
        if (take) begin
            exp_q.push_back(ptr);
            if (has_flag(ptr, F_TAKEN)) begin
                pending_redirect = 1'b1;
            end
            if (has_flag(ptr, F_STALL)) begin
                stall_left = LONG_STALL;
            end
            ptr++;
        end
    endtask

    initial begin
        seed = 32'hb2c7;
        void'($urandom(seed));
        $readmemh("verif/ooo_trace.txt", trace_mem);
        dispatch_valid_i = 1'b0;
        dispatch_op_i    = OP_ADD;
        dispatch_rd_i    = '0;
        dispatch_rs1_i   = '0;
        dispatch_rs2_i   = '0;
        dispatch_pc_i    = '0;
        dispatch_imm_i   = '0;
        commit_ready_i   = 1'b1;
        ptr              = 0;
        stall_left       = 0;
        cycles           = 0;
        errors           = 0;
        checks           = 0;
        pending_redirect = 1'b0;
        timed_out        = 1'b0;

        @(posedge rst_n);
        @(negedge clk);
        #1;
        // idle outputs out of reset
        check_value("full_o", full_o, 1'b0);
        check_value("commit_valid_o", commit_valid_o, 1'b0);
        check_value("redirect_valid_o", redirect_valid_o, 1'b0);

        while ((ptr < LINES || exp_q.size() != 0) && !timed_out) begin
            @(negedge clk);
            cycles++;
            if (cycles > CYCLE_LIMIT) begin
                timed_out = 1'b1;
                errors++;
                $display("timeout: run stopped after %0d cycles, %0d lines still outstanding",
                         cycles, exp_q.size());
            end else begin
                drive_inputs();
                #1;
                sample_outputs();
            end
        end

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule
